/* build.f */
ecc_pkg.sv
secded_enc.sv
secded_dec.sv
sram_bank.sv
ecc_scrubber.sv
ecc_sram.sv
tb_ecc_sram.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0
TOP       := tb_ecc_sram
FILELIST  := build.f
OBJDIR    := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

/* tb_ecc_sram.sv */
// ---------------------------------------------------------------------------
// Testbench for the ECC-protected SRAM
//   LFSR random source, reference model of data and injected bits
//   Port tasks for reads, full and partial writes, scrubber waits
//   Tests for plain access, RMW stall, injection and scrubbing
// ---------------------------------------------------------------------------

module tb_ecc_sram;

  timeunit 1ns;
  timeprecision 1ps;

  import ecc_pkg::*;

  localparam int unsigned NumRmwCuts = 1;
  localparam int unsigned WaitLimit  = 64; // Cycles allowed for a grant

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i;
  mem_req_t             mem_req_i;
  logic                 gnt_o;
  logic [DataWidth-1:0] rdata_o;
  ecc_err_t             err_o;
  logic                 scrub_trigger_i;
  logic                 scrub_fix_o;
  logic                 scrub_uncorrectable_o;

  logic [15:0]          lfsr_q;
  logic [DataWidth-1:0] model_mem [NumWords];
  logic [CodeWidth-1:0] model_inj [NumWords]; // Bits flipped in the stored codeword
  int unsigned          num_tests, num_checks, num_errors, err_base;

  ecc_sram #(.NumRmwCuts(NumRmwCuts)) dut0 (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Taps 16, 14, 13, 11; one step per bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    num_checks++;
    if (expected !== actual) begin
      num_errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic abort_run(string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic end_test(string name);
    num_tests++;
    $display("test %s: %s", name, (num_errors == err_base) ? "ok" : "errors found");
    err_base = num_errors;
  endtask

  // Holds req_i until gnt_o, returns just after the accepting edge
  task automatic issue(mem_req_t r, string what);
    int unsigned n;
    n         = 0;
    req_i     = 1'b1;
    mem_req_i = r;
    while (!gnt_o) begin
      n++;
      if (n > WaitLimit) begin
        abort_run($sformatf("Timeout: no grant for a %s request", what));
      end
      @(posedge clk_i);
      #10;
    end
    @(posedge clk_i);
    #10;
    req_i = 1'b0;
  endtask

  task automatic write_word(logic [AddrWidth-1:0] addr, logic [DataWidth-1:0] data,
                            logic [NumBytes-1:0] be, logic [CodeWidth-1:0] inj);
    mem_req_t r;
    r = '{we: 1'b1, addr: addr, wdata: data, be: be, inj_mask: inj};
    issue(r, "write");
    for (int b = 0; b < NumBytes; b++) begin
      if (be[b]) model_mem[addr][b*ByteWidth +: ByteWidth] = data[b*ByteWidth +: ByteWidth];
    end
    model_inj[addr] = inj;
  endtask

  task automatic read_check(logic [AddrWidth-1:0] addr, string name);
    mem_req_t r;
    ecc_err_t exp_err;
    r = '{we: 1'b0, addr: addr, wdata: '0, be: '0, inj_mask: '0};
    exp_err.single = ($countones(model_inj[addr]) == 1);
    exp_err.multi  = ($countones(model_inj[addr]) == 2);
    issue(r, "read");
    if (!exp_err.multi) check_value(name, 64'(model_mem[addr]), 64'(rdata_o));
    check_value(name, 64'(exp_err), 64'(err_o));
  endtask

  // Counts the cycles with the grant low after a partial write
  task automatic check_rmw_stall(string name);
    int unsigned low;
    low = 0;
    while (!gnt_o) begin
      low++;
      if (low > WaitLimit) abort_run("Timeout: grant stuck low after a partial write");
      @(posedge clk_i);
      #10;
    end
    check_value(name, 64'(NumRmwCuts + 1), 64'(low));
  endtask

  task automatic wait_scrub(logic want_fix, string name);
    int unsigned n;
    n               = 0;
    scrub_trigger_i = 1'b1;
    while (!(want_fix ? scrub_fix_o : scrub_uncorrectable_o)) begin
      n++;
      if (n > NumWords * 4) abort_run($sformatf("Timeout: scrubber never reported %s", name));
      @(posedge clk_i);
      #10;
    end
    scrub_trigger_i = 1'b0;
    @(posedge clk_i);
    #10;
  endtask

  initial begin
    logic [AddrWidth-1:0] addr;
    logic [NumBytes-1:0]  be;
    int unsigned          p1, p2;
    lfsr_q          = 16'd47;
    num_tests       = 0;
    num_checks      = 0;
    num_errors      = 0;
    err_base        = 0;
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    mem_req_i       = '0;
    scrub_trigger_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    for (int a = 0; a < NumWords; a++) begin // Every word gets a clean value first
      write_word(AddrWidth'(a), rand_bits(DataWidth), '1, '0);
    end
    for (int k = 0; k < 64; k++) read_check(AddrWidth'(rand_bits(AddrWidth)), "full_rw");
    end_test("full_rw");

    for (int k = 0; k < 32; k++) begin
      addr = AddrWidth'(rand_bits(AddrWidth));
      be   = NumBytes'(rand_bits(NumBytes));
      if (be == '1) be[0] = 1'b0;
      write_word(addr, rand_bits(DataWidth), be, '0);
      check_rmw_stall("partial_write");
      read_check(addr, "partial_write");
    end
    end_test("partial_write");

    for (int k = 0; k < 8; k++) begin
      addr = AddrWidth'(rand_bits(AddrWidth));
      p1   = rand_bits(6) % CodeWidth;
      write_word(addr, rand_bits(DataWidth), '1, CodeWidth'(1) << p1);
      read_check(addr, "single_inject");
      write_word(addr, model_mem[addr], '1, '0); // Leave no single error behind
    end
    end_test("single_inject");

    for (int k = 0; k < 4; k++) begin
      addr = AddrWidth'(rand_bits(AddrWidth));
      p1   = rand_bits(6) % CodeWidth;
      p2   = (p1 + 1 + rand_bits(6) % (CodeWidth - 1)) % CodeWidth;
      write_word(addr, rand_bits(DataWidth), '1, (CodeWidth'(1) << p1) | (CodeWidth'(1) << p2));
      read_check(addr, "double_inject");
    end
    end_test("double_inject");

    addr = AddrWidth'(rand_bits(AddrWidth));
    p1   = rand_bits(6) % CodeWidth;
    write_word(addr, rand_bits(DataWidth), '1, CodeWidth'(1) << p1);
    wait_scrub(1'b1, "a fix");
    model_inj[addr] = '0; // Scrubber rewrote the clean codeword
    read_check(addr, "scrub_fix");
    end_test("scrub_fix");

    wait_scrub(1'b0, "an uncorrectable word");
    end_test("scrub_uncorrectable");

    $display("tests: %0d, checks: %0d, errors: %0d", num_tests, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* ecc_sram.sv */
// ---------------------------------------------------------------------------
// ECC-protected single-port SRAM, top level
//   Read-modify-write controller for partial writes, with delay line
//   Hsiao encoder and decoder, fault injection on writes
//   Background scrubber and codeword bank
// ---------------------------------------------------------------------------

module ecc_sram #(
  parameter int unsigned NumRmwCuts = 1 // Idle cycles between RMW read and write
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  ecc_pkg::mem_req_t             mem_req_i,
  output logic                          gnt_o,
  output logic [ecc_pkg::DataWidth-1:0] rdata_o,
  output ecc_pkg::ecc_err_t             err_o,
  input  logic                          scrub_trigger_i,
  output logic                          scrub_fix_o,
  output logic                          scrub_uncorrectable_o
);

  import ecc_pkg::*;

  localparam int unsigned CntWidth = (NumRmwCuts > 0) ? $clog2(NumRmwCuts + 1) : 1;

  typedef enum logic { NORMAL, READ_MODIFY_WRITE } store_state_e;
  store_state_e state_d, state_q;

  logic [CntWidth-1:0]  cnt_d, cnt_q;
  mem_req_t             buf_q;
  logic                 buf_load, partial;
  logic                 valid_d, valid_q;

  logic                 bank_req, sram_req;
  bank_req_t            bank_breq, sram_breq;
  logic [CodeWidth-1:0] bank_rdata, sram_rdata, rmw_code, dec_in, enc_code;
  logic [DataWidth-1:0] enc_data, dec_data, be_mask, merged;
  ecc_err_t             dec_err;

  assign partial = mem_req_i.we && (mem_req_i.be != '1);
  assign valid_d = req_i && gnt_o && !mem_req_i.we; // Only user reads report errors

  // Old word travels NumRmwCuts stages while the port is held off
  if (NumRmwCuts == 0) begin : gen_no_cut
    assign rmw_code = bank_rdata;
  end else begin : gen_cut
    logic [NumRmwCuts-1:0][CodeWidth-1:0] delay_q;
    always_ff @(posedge clk_i) begin
      delay_q[0] <= bank_rdata;
      for (int k = 1; k < NumRmwCuts; k++) begin
        delay_q[k] <= delay_q[k-1];
      end
    end
    assign rmw_code = delay_q[NumRmwCuts-1];
  end

  for (genvar b = 0; b < NumBytes; b++) begin : gen_be_mask
    assign be_mask[b*ByteWidth +: ByteWidth] = {ByteWidth{buf_q.be[b]}};
  end

  assign merged = (be_mask & buf_q.wdata) | (~be_mask & dec_data);
  assign dec_in = (state_q == NORMAL) ? bank_rdata : rmw_code;

  secded_dec i_dec (
    .code_i     (dec_in),
    .data_o     (dec_data),
    .syndrome_o (),
    .err_o      (dec_err)
  );

  secded_enc i_enc (
    .data_i (enc_data),
    .code_o (enc_code)
  );

  always_comb begin
    state_d         = state_q;
    cnt_d           = cnt_q;
    gnt_o           = 1'b1;
    buf_load        = 1'b0;
    enc_data        = mem_req_i.wdata;
    bank_req        = req_i;
    bank_breq.we    = mem_req_i.we && !partial; // Partial write starts with a read
    bank_breq.addr  = mem_req_i.addr;
    bank_breq.wdata = enc_code ^ mem_req_i.inj_mask;
    if (state_q == NORMAL) begin
      if (req_i && partial) begin
        state_d  = READ_MODIFY_WRITE;
        cnt_d    = CntWidth'(NumRmwCuts);
        buf_load = 1'b1;
      end
    end else begin
      gnt_o           = 1'b0;
      enc_data        = merged;
      bank_breq.we    = 1'b1;
      bank_breq.addr  = buf_q.addr;
      bank_breq.wdata = enc_code ^ buf_q.inj_mask;
      if (cnt_q == '0) begin
        bank_req = 1'b1; // Write back the merged word
        state_d  = NORMAL;
      end else begin
        bank_req = 1'b0;
        cnt_d    = cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= NORMAL;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_load) buf_q <= mem_req_i;
  end

  assign rdata_o      = dec_data;
  assign err_o.single = dec_err.single & valid_q;
  assign err_o.multi  = dec_err.multi & valid_q;

  ecc_scrubber i_scrubber (
    .clk_i,
    .rst_ni,
    .scrub_trigger_i       (scrub_trigger_i),
    .intc_req_i            (bank_req),
    .intc_breq_i           (bank_breq),
    .intc_rdata_o          (bank_rdata),
    .bank_req_o            (sram_req),
    .bank_breq_o           (sram_breq),
    .bank_rdata_i          (sram_rdata),
    .scrub_fix_o           (scrub_fix_o),
    .scrub_uncorrectable_o (scrub_uncorrectable_o)
  );

  sram_bank i_bank (
    .clk_i,
    .rst_ni,
    .req_i   (sram_req),
    .breq_i  (sram_breq),
    .rdata_o (sram_rdata)
  );

  // Grant comes back NumRmwCuts+1 cycles after a partial write was accepted
  a_rmw_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(gnt_o) |-> $past(req_i && gnt_o && partial, NumRmwCuts + 2))
    else $error("grant returned at the wrong cycle after a partial write");

  // The internal read of a read-modify-write raises no flags
  a_rmw_no_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !gnt_o |-> !err_o.single && !err_o.multi)
    else $error("error flagged during a read-modify-write");

endmodule

/* ecc_scrubber.sv */
// ---------------------------------------------------------------------------
// Background scrubber
//   Idle/read/check/fix FSM and address counter
//   Bank arbitration, the user side always wins
//   Write-back of corrected words, report of uncorrectable ones
// ---------------------------------------------------------------------------

module ecc_scrubber (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          scrub_trigger_i,
  input  logic                          intc_req_i,
  input  ecc_pkg::bank_req_t            intc_breq_i,
  output logic [ecc_pkg::CodeWidth-1:0] intc_rdata_o,
  output logic                          bank_req_o,
  output ecc_pkg::bank_req_t            bank_breq_o,
  input  logic [ecc_pkg::CodeWidth-1:0] bank_rdata_i,
  output logic                          scrub_fix_o,
  output logic                          scrub_uncorrectable_o
);

  import ecc_pkg::*;

  typedef enum logic [1:0] { IDLE, READ, CHECK, FIX } scrub_state_e;
  scrub_state_e state_d, state_q, resume;

  logic [AddrWidth-1:0] addr_d, addr_q, addr_next;
  logic [CodeWidth-1:0] fix_code_q, enc_code;
  logic                 fix_load, fix_d, fix_q, unc_d, unc_q;
  logic                 scrub_req;
  bank_req_t            scrub_breq;

  logic [DataWidth-1:0] dec_data;
  ecc_err_t             dec_err;

  secded_dec i_dec (
    .code_i     (bank_rdata_i),
    .data_o     (dec_data),
    .syndrome_o (),
    .err_o      (dec_err)
  );

  secded_enc i_enc (
    .data_i (dec_data),
    .code_o (enc_code)
  );

  assign addr_next = (addr_q == AddrWidth'(NumWords - 1)) ? '0 : addr_q + 1'b1;
  assign resume    = scrub_trigger_i ? READ : IDLE;

  always_comb begin
    state_d          = state_q;
    addr_d           = addr_q;
    scrub_req        = 1'b0;
    scrub_breq.we    = 1'b0;
    scrub_breq.addr  = addr_q;
    scrub_breq.wdata = fix_code_q;
    fix_load         = 1'b0;
    fix_d            = 1'b0;
    unc_d            = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (scrub_trigger_i) state_d = READ;
      end
      READ: begin
        if (!scrub_trigger_i) begin
          state_d = IDLE;
        end else if (!intc_req_i) begin
          scrub_req = 1'b1; // Read slot is free
          state_d   = CHECK;
        end
      end
      CHECK: begin
        if (dec_err.multi) begin
          unc_d   = 1'b1;
          addr_d  = addr_next;
          state_d = resume;
        end else if (dec_err.single) begin
          if (intc_req_i) begin
            state_d = READ; // User touched the bank, re-read
          end else begin
            fix_load = 1'b1;
            state_d  = FIX;
          end
        end else begin
          addr_d  = addr_next;
          state_d = resume;
        end
      end
      FIX: begin
        if (intc_req_i) begin
          state_d = READ; // Stored fix may be stale now
        end else begin
          scrub_req     = 1'b1;
          scrub_breq.we = 1'b1;
          fix_d         = 1'b1;
          addr_d        = addr_next;
          state_d       = resume;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      fix_q   <= 1'b0;
      unc_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      fix_q   <= fix_d;
      unc_q   <= unc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fix_load) fix_code_q <= enc_code;
  end

  assign bank_req_o            = intc_req_i | scrub_req;
  assign bank_breq_o           = intc_req_i ? intc_breq_i : scrub_breq;
  assign intc_rdata_o          = bank_rdata_i;
  assign scrub_fix_o           = fix_q;
  assign scrub_uncorrectable_o = unc_q;

  // No user access between the scrub read and its write-back
  a_no_collision: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrub_req && scrub_breq.we |-> !$past(intc_req_i) && !$past(intc_req_i, 2))
    else $error("scrubber writes back a word the user side may have changed");

endmodule

/* sram_bank.sv */
// ---------------------------------------------------------------------------
// Single-port codeword array
// Synchronous write, read data registered and held until the next read
// ---------------------------------------------------------------------------

module sram_bank (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  ecc_pkg::bank_req_t            breq_i,
  output logic [ecc_pkg::CodeWidth-1:0] rdata_o
);

  import ecc_pkg::*;

  logic [CodeWidth-1:0] mem_q [NumWords];
  logic [CodeWidth-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i && breq_i.we) begin
      mem_q[breq_i.addr] <= breq_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !breq_i.we) begin
      rdata_q <= mem_q[breq_i.addr]; // One cycle read latency
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* secded_dec.sv */
// ---------------------------------------------------------------------------
// Hsiao (39,32) SECDED decoder
//   Syndrome computation
//   Single-bit correction of the data bits
//   Single and multi error classification
// ---------------------------------------------------------------------------

module secded_dec (
  input  logic [  ecc_pkg::CodeWidth-1:0] code_i,
  output logic [  ecc_pkg::DataWidth-1:0] data_o,
  output logic [ecc_pkg::ParityWidth-1:0] syndrome_o,
  output ecc_pkg::ecc_err_t               err_o
);

  import ecc_pkg::*;

  logic [  DataWidth-1:0] data;
  logic [ParityWidth-1:0] check;
  logic [ParityWidth-1:0] syndrome;

  assign data  = code_i[DataWidth-1:0];
  assign check = code_i[CodeWidth-1:DataWidth];

  // Recomputed check bits against the stored ones
  always_comb begin
    syndrome = check;
    for (int j = 0; j < ParityWidth; j++) begin
      for (int i = 0; i < DataWidth; i++) begin
        syndrome[j] = syndrome[j] ^ (data[i] & HsiaoCols[i][j]);
      end
    end
  end

  // Flip the data bit whose column matches the syndrome
  always_comb begin
    data_o = data;
    for (int i = 0; i < DataWidth; i++) begin
      if (syndrome == HsiaoCols[i]) begin
        data_o[i] = ~data[i];
      end
    end
  end

  assign syndrome_o   = syndrome;
  assign err_o.single = ^syndrome;                // Odd weight, one bit flipped
  assign err_o.multi  = (|syndrome) & ~(^syndrome); // Even weight, nonzero

endmodule

/* secded_enc.sv */
// ---------------------------------------------------------------------------
// Hsiao (39,32) SECDED encoder
// Seven check bits are appended above the 32 data bits
// ---------------------------------------------------------------------------

module secded_enc (
  input  logic [ecc_pkg::DataWidth-1:0] data_i,
  output logic [ecc_pkg::CodeWidth-1:0] code_o
);

  import ecc_pkg::*;

  logic [ParityWidth-1:0] check;

  // Each check bit covers the data bits whose column has a one in its row
  always_comb begin
    check = '0;
    for (int j = 0; j < ParityWidth; j++) begin
      for (int i = 0; i < DataWidth; i++) begin
        check[j] = check[j] ^ (data_i[i] & HsiaoCols[i][j]);
      end
    end
  end

  assign code_o = {check, data_i};

endmodule

/* ecc_pkg.sv */
// ---------------------------------------------------------------------------
// Shared definitions for the ECC-protected SRAM
//   Word, codeword and address widths
//   User request, bank access and error flag structs
//   Hsiao (39,32) parity-check column table
// ---------------------------------------------------------------------------

package ecc_pkg;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned ParityWidth = 7;
  localparam int unsigned CodeWidth   = DataWidth + ParityWidth;
  localparam int unsigned NumWords    = 256;
  localparam int unsigned AddrWidth   = $clog2(NumWords);
  localparam int unsigned ByteWidth   = 8;
  localparam int unsigned NumBytes    = DataWidth / ByteWidth;

  // One column per data bit, all of weight three and distinct.
  // Check bits use the unit columns, so every column has odd weight.
  localparam logic [DataWidth-1:0][ParityWidth-1:0] HsiaoCols = {
    7'h62, 7'h61, 7'h58, 7'h54, 7'h52, 7'h51, 7'h4c, 7'h4a,
    7'h49, 7'h46, 7'h45, 7'h43, 7'h38, 7'h34, 7'h32, 7'h31,
    7'h2c, 7'h2a, 7'h29, 7'h26, 7'h25, 7'h23, 7'h1c, 7'h1a,
    7'h19, 7'h16, 7'h15, 7'h13, 7'h0e, 7'h0d, 7'h0b, 7'h07
  };

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [NumBytes-1:0]  be;
    logic [CodeWidth-1:0] inj_mask; // XORed into the stored codeword
  } mem_req_t;

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [CodeWidth-1:0] wdata;
  } bank_req_t;

  typedef struct packed {
    logic single; // Corrected
    logic multi;  // Detected, not correctable
  } ecc_err_t;

endpackage
